// File: Makefile
TOP := processorTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: dv/processorTb.sv
`timescale 1ns/1ps
`default_nettype none

module processorTb;
    import procPkg::*;

    localparam int NumRows     = 6;
    localparam int ProgLen     = 16;
    localparam int MaxOut      = 16;
    localparam int ResetCycles = 3;
    localparam int DrainCycles = 8;
    localparam int ClkPeriod   = 8;
    // load, reset, drain, plus the run budget of 4 cycles per word and slack
    localparam int RowCycles   = ProgLen + ResetCycles + DrainCycles + ProgLen * 4 + 30;

    logic clk;
    logic rstN;
    logic progWe;
    dataT progAddr;
    dataT progData;
    dataT inPort;
    dataT outPort;
    logic outValid;
    logic halted;
    logic stackOverflow;

    // stimulus table, one program and its expected OUT stream per row
    dataT progTable [NumRows][ProgLen];
    dataT expTable  [NumRows][MaxOut];
    int   expCount  [NumRows];
    // expected value is inPort plus the table entry
    logic relToIn   [NumRows];
    logic expOverflow [NumRows];

    int          errorCount;
    int          checkCount;
    int          outSeen;
    logic [31:0] lcgState;
    dataT        inValue;

    processor #(
        .ImemDepth(256),
        .DmemDepth(256),
        .StackDepth(16)
    ) DUT (
        .clk(clk),
        .rstN(rstN),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .inPort(inPort),
        .outPort(outPort),
        .outValid(outValid),
        .halted(halted),
        .stackOverflow(stackOverflow)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // hard stop sized from the row budget
    initial begin
        #(NumRows * RowCycles * ClkPeriod);
        $display("watchdog expired, a program never reached halted or stackOverflow");
        $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // register form: opcode rd rs rt func
    function automatic dataT regInstr(opcodeT op, int rd, int rs, int rt, aluFuncT f);
        return {op, rd[2:0], rs[2:0], rt[2:0], f};
    endfunction

    // immediate form: opcode rd rs imm6
    function automatic dataT immInstr(opcodeT op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    task automatic buildTable();
        for (int r = 0; r < NumRows; r++) begin
            for (int i = 0; i < ProgLen; i++) begin
                progTable[r][i] = immInstr(HALT, 0, 0, 0);
            end
            for (int i = 0; i < MaxOut; i++) begin
                expTable[r][i] = '0;
            end
            relToIn[r]     = 1'b0;
            expOverflow[r] = 1'b0;
        end

        // row 0, dependent ALU and ADDI chain
        progTable[0][0]  = immInstr(ADDI, 1, 0, 5);
        progTable[0][1]  = immInstr(ADDI, 2, 1, 3);
        progTable[0][2]  = regInstr(ALU, 3, 1, 2, ADD);
        progTable[0][3]  = regInstr(ALU, 4, 3, 1, SUB);
        progTable[0][4]  = regInstr(ALU, 5, 4, 1, SHL);
        progTable[0][5]  = immInstr(OUT, 0, 3, 0);
        progTable[0][6]  = immInstr(OUT, 0, 4, 0);
        progTable[0][7]  = immInstr(OUT, 0, 5, 0);
        progTable[0][8]  = regInstr(ALU, 6, 5, 2, XOR);
        progTable[0][9]  = immInstr(ADDI, 7, 6, -9);
        progTable[0][10] = immInstr(OUT, 0, 6, 0);
        progTable[0][11] = immInstr(OUT, 0, 7, 0);
        // write aimed at r0, read back at once
        progTable[0][12] = immInstr(ADDI, 0, 1, 3);
        progTable[0][13] = immInstr(OUT, 0, 0, 0);
        // 5+3, 5+8, 13-5, 8<<5, 0x100^8, 0x108-9
        expTable[0][0] = 16'h000D;
        expTable[0][1] = 16'h0008;
        expTable[0][2] = 16'h0100;
        expTable[0][3] = 16'h0108;
        expTable[0][4] = 16'h00FF;
        // r0 still reads zero
        expTable[0][5] = 16'h0000;
        expCount[0]    = 6;

        // row 1, store then load used at once
        progTable[1][0] = immInstr(ADDI, 1, 0, 20);
        progTable[1][1] = immInstr(ADDI, 2, 0, 10);
        progTable[1][2] = immInstr(ST, 1, 2, 3);
        progTable[1][3] = immInstr(LD, 3, 2, 3);
        progTable[1][4] = immInstr(ADDI, 4, 3, 1);
        progTable[1][5] = immInstr(OUT, 0, 4, 0);
        progTable[1][6] = immInstr(LD, 5, 2, 3);
        progTable[1][7] = immInstr(OUT, 0, 5, 0);
        expTable[1][0]  = 16'h0015;
        expTable[1][1]  = 16'h0014;
        expCount[1]     = 2;

        // row 2, JZ not taken, JZ taken, JMP; shadow slots hold OUTs
        progTable[2][0]  = immInstr(ADDI, 1, 0, 1);
        progTable[2][1]  = immInstr(ADDI, 2, 0, 7);
        progTable[2][2]  = immInstr(JZ, 0, 2, 0);
        progTable[2][3]  = immInstr(OUT, 0, 1, 0);
        progTable[2][4]  = immInstr(ADDI, 3, 0, 0);
        progTable[2][5]  = immInstr(JZ, 0, 2, 0);
        progTable[2][6]  = immInstr(OUT, 0, 2, 0);
        progTable[2][7]  = immInstr(ADDI, 4, 0, 12);
        progTable[2][8]  = immInstr(JMP, 0, 4, 0);
        progTable[2][9]  = immInstr(OUT, 0, 4, 0);
        progTable[2][10] = immInstr(OUT, 0, 2, 0);
        progTable[2][11] = immInstr(OUT, 0, 1, 0);
        progTable[2][12] = immInstr(OUT, 0, 4, 0);
        expTable[2][0]   = 16'h0001;
        expTable[2][1]   = 16'h000C;
        expCount[2]      = 2;

        // row 3, stack comes back reversed
        progTable[3][0]  = immInstr(ADDI, 1, 0, 11);
        progTable[3][1]  = immInstr(ADDI, 2, 0, 22);
        progTable[3][2]  = immInstr(ADDI, 3, 0, 29);
        progTable[3][3]  = immInstr(PUSH, 0, 1, 0);
        progTable[3][4]  = immInstr(PUSH, 0, 2, 0);
        progTable[3][5]  = immInstr(PUSH, 0, 3, 0);
        progTable[3][6]  = immInstr(POP, 4, 0, 0);
        progTable[3][7]  = immInstr(POP, 5, 0, 0);
        progTable[3][8]  = immInstr(POP, 6, 0, 0);
        progTable[3][9]  = immInstr(OUT, 0, 4, 0);
        progTable[3][10] = immInstr(OUT, 0, 5, 0);
        progTable[3][11] = immInstr(OUT, 0, 6, 0);
        expTable[3][0]   = 16'h001D;
        expTable[3][1]   = 16'h0016;
        expTable[3][2]   = 16'h000B;
        expCount[3]      = 3;

        // row 4, input port through ADDI
        progTable[4][0] = immInstr(IN, 1, 0, 0);
        progTable[4][1] = immInstr(ADDI, 2, 1, -7);
        progTable[4][2] = immInstr(OUT, 0, 2, 0);
        progTable[4][3] = immInstr(OUT, 0, 1, 0);
        expTable[4][0]  = 16'hFFF9;
        expTable[4][1]  = 16'h0000;
        expCount[4]     = 2;
        relToIn[4]      = 1'b1;

        // row 5, push loop until the stack overflows
        progTable[5][0] = immInstr(IN, 1, 0, 0);
        progTable[5][1] = immInstr(ADDI, 2, 0, 2);
        progTable[5][2] = immInstr(PUSH, 0, 1, 0);
        progTable[5][3] = immInstr(OUT, 0, 1, 0);
        progTable[5][4] = immInstr(JMP, 0, 2, 0);
        // one OUT per accepted push, 16 fit
        expCount[5]    = 16;
        relToIn[5]     = 1'b1;
        expOverflow[5] = 1'b1;
    endtask

    // reset, load all words, hold reset, release
    task automatic resetAndLoad(int row, dataT value);
        @(posedge clk);
        rstN   <= 1'b0;
        progWe <= 1'b0;
        inPort <= value;
        for (int i = 0; i < ProgLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= dataT'(i);
            progData <= progTable[row][i];
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic checkOutput(int row);
        dataT expected;
        checkCount++;
        assert (outSeen < expCount[row]) else begin
            errorCount++;
            $display("row %0d gave an extra output %h beyond the %0d expected",
                     row, outPort, expCount[row]);
        end
        if (outSeen < expCount[row]) begin
            expected = relToIn[row] ? inValue + expTable[row][outSeen] : expTable[row][outSeen];
            assert (outPort == expected) else begin
                errorCount++;
                $display("error: outPort = %h, expected %h (row %0d, output %0d)",
                         outPort, expected, row, outSeen);
            end
        end
        outSeen++;
    endtask

    task automatic runRow(int row);
        outSeen = 0;
        while (!(halted || stackOverflow)) begin
            @(negedge clk);
            if (outValid) begin
                checkOutput(row);
            end
        end
        // nothing may come out once the core has stopped
        repeat (DrainCycles) begin
            @(negedge clk);
            if (outValid) begin
                checkOutput(row);
            end
        end
        checkCount++;
        assert (outSeen == expCount[row]) else begin
            errorCount++;
            $display("row %0d produced %0d outputs instead of %0d", row, outSeen, expCount[row]);
        end
        assert (stackOverflow == expOverflow[row]) else begin
            errorCount++;
            $display("error: stackOverflow = %h, expected %h (row %0d)",
                     stackOverflow, expOverflow[row], row);
        end
        assert (halted == !expOverflow[row]) else begin
            errorCount++;
            $display("error: halted = %h, expected %h (row %0d)", halted, !expOverflow[row], row);
        end
    endtask

    initial begin
        rstN       = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        inPort     = '0;
        errorCount = 0;
        checkCount = 0;
        outSeen    = 0;
        lcgState   = 32'd5032;
        inValue    = '0;
        buildTable();

        for (int row = 0; row < NumRows; row++) begin
            lcgState = lcgNext(lcgState);
            inValue  = lcgState[31:16];
            resetAndLoad(row, inValue);
            runRow(row);
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/procPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/forwardUnit.sv
src/executeStage.sv
src/memoryStage.sv
src/processor.sv
dv/processorTb.sv

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  procPkg::ifIdT     ifId,
    input  logic              stall,
    input  logic              flush,
    input  logic              wbEn,
    input  procPkg::regAddrT  wbAddr,
    input  procPkg::dataT     wbData,
    input  procPkg::dataT     inPort,
    output procPkg::idExT     idEx,
    output procPkg::regAddrT  decRs,
    output procPkg::regAddrT  decRt
);
    import procPkg::*;

    instrWordT iw;
    opcodeT    op;
    ctrlT      ctrl;
    dataT      regs [8];
    dataT      rdA;
    dataT      rdB;
    dataT      imm;
    logic      rsUsed;

    assign iw = ifId.instr;
    assign op = iw.regForm.opcode;

    // sign-extend through the immediate view of the word
    assign imm = {{10{iw.immForm.imm[5]}}, iw.immForm.imm};

    // sources are zeroed when unused so no false stall or bypass
    assign rsUsed = ifId.valid && !(op inside {NOP, POP, IN, HALT});
    assign decRs  = rsUsed ? iw.regForm.rs : '0;

    always_comb begin
        decRt = '0;
        if (ifId.valid && op == ALU) begin
            decRt = iw.regForm.rt;
        end else if (ifId.valid && op == ST) begin
            // store data comes from the rd field
            decRt = iw.regForm.rd;
        end
    end

    always_comb begin
        ctrl         = '0;
        ctrl.aluFunc = ADD;
        case (op)
            ALU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = iw.regForm.func;
            end
            ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            LD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            ST: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            PUSH: ctrl.isPush = 1'b1;
            POP: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.isPop    = 1'b1;
            end
            IN: begin
                ctrl.regWrite = 1'b1;
                ctrl.isIn     = 1'b1;
            end
            OUT:  ctrl.isOut  = 1'b1;
            JZ:   ctrl.isJz   = 1'b1;
            JMP:  ctrl.isJmp  = 1'b1;
            HALT: ctrl.isHalt = 1'b1;
            default: ;
        endcase
    end

    // write-first, same-cycle write shows on the read ports
    assign rdA = (wbEn && wbAddr == decRs && decRs != '0) ? wbData : regs[decRs];
    assign rdB = (wbEn && wbAddr == decRt && decRt != '0) ? wbData : regs[decRt];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (flush || stall) begin
            // bubble into execute
            idEx <= '0;
        end else begin
            idEx.pc    <= ifId.pc;
            idEx.ctrl  <= ctrl;
            idEx.opA   <= rdA;
            idEx.opB   <= ctrl.isIn ? inPort : rdB;
            idEx.imm   <= imm;
            idEx.rs    <= decRs;
            idEx.rt    <= decRt;
            idEx.rd    <= iw.regForm.rd;
            idEx.valid <= ifId.valid;
        end
    end

    // r0 survives any writeback aimed at it
    assert property (@(posedge clk) disable iff (!rstN)
        (wbEn && wbAddr == '0) |=> regs[0] == '0)
        else $error("r0 overwritten");

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::idExT   idEx,
    input  logic [1:0]      fwdA,
    input  logic [1:0]      fwdB,
    input  procPkg::dataT   exFwdData,
    input  procPkg::dataT   wbFwdData,
    output procPkg::exMemT  exMem,
    output logic            branchTaken,
    output procPkg::dataT   branchTarget
);
    import procPkg::*;

    dataT a;
    dataT b;
    dataT aluB;
    dataT aluOut;
    dataT result;
    logic zFlag;
    logic setsFlag;

    function automatic dataT pickOperand(logic [1:0] sel, dataT regVal,
                                         dataT memVal, dataT wbVal);
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign a    = pickOperand(fwdA, idEx.opA, exFwdData, wbFwdData);
    assign b    = pickOperand(fwdB, idEx.opB, exFwdData, wbFwdData);
    // address add for LD and ST goes through the same adder
    assign aluB = idEx.ctrl.useImm ? idEx.imm : b;

    always_comb begin
        case (idEx.ctrl.aluFunc)
            ADD:     aluOut = a + aluB;
            SUB:     aluOut = a - aluB;
            AND:     aluOut = a & aluB;
            OR:      aluOut = a | aluB;
            XOR:     aluOut = a ^ aluB;
            SHL:     aluOut = a << aluB[3:0];
            SHR:     aluOut = a >> aluB[3:0];
            default: aluOut = ~a;
        endcase
    end

    // IN carries inPort in b, OUT passes rs through
    assign result = idEx.ctrl.isIn ? b : (idEx.ctrl.isOut ? a : aluOut);

    // only ALU and ADDI touch the flag
    assign setsFlag = idEx.valid && idEx.ctrl.regWrite && !idEx.ctrl.memToReg
                      && !idEx.ctrl.isIn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            zFlag <= 1'b0;
        end else if (setsFlag) begin
            zFlag <= (aluOut == '0);
        end
    end

    // JZ sees the flag left by older instructions
    assign branchTaken  = idEx.valid && (idEx.ctrl.isJmp || (idEx.ctrl.isJz && zFlag));
    assign branchTarget = a;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.pc        <= idEx.pc;
            exMem.ctrl      <= idEx.ctrl;
            exMem.result    <= result;
            // PUSH stores rs, ST stores rd routed through b
            exMem.storeData <= idEx.ctrl.isPush ? a : b;
            exMem.rd        <= idEx.rd;
            exMem.valid     <= idEx.valid;
        end
    end

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int ImemDepth = 256
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           progWe,
    input  procPkg::dataT  progAddr,
    input  procPkg::dataT  progData,
    input  logic           stall,
    input  logic           flush,
    input  logic           branchTaken,
    input  procPkg::dataT  branchTarget,
    input  logic           stop,
    output procPkg::ifIdT  ifId
);
    import procPkg::*;

    localparam int Iaw = $clog2(ImemDepth);

    dataT      imem [ImemDepth];
    dataT      pc;
    instrWordT fetched;
    // a HALT is already in the pipe, nothing behind it may issue
    logic      haltSeen;

    // loader writes only while the core is held in reset
    always_ff @(posedge clk) begin
        if (progWe && !rstN) begin
            imem[progAddr[Iaw-1:0]] <= progData;
        end
    end

    assign fetched = imem[pc[Iaw-1:0]];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            haltSeen <= 1'b0;
            ifId     <= '0;
        end else if (flush) begin
            // shadow of a taken branch, a HALT in it never counted
            ifId.valid <= 1'b0;
            haltSeen   <= 1'b0;
            if (branchTaken) begin
                pc <= branchTarget;
            end
        end else if (!stall) begin
            if (stop || haltSeen) begin
                ifId.valid <= 1'b0;
            end else begin
                ifId.pc    <= pc;
                ifId.instr <= fetched;
                ifId.valid <= 1'b1;
                pc         <= pc + 16'd1;
                haltSeen   <= (fetched.regForm.opcode == HALT);
            end
        end
    end

    // program port is a reset-time path only
    assert property (@(posedge clk) rstN |-> !progWe)
        else $error("progWe asserted outside reset");

endmodule

`default_nettype wire

// File: src/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  procPkg::idExT   idEx,
    input  procPkg::exMemT  exMem,
    input  procPkg::memWbT  memWb,
    output logic [1:0]      fwdA,
    output logic [1:0]      fwdB
);
    import procPkg::*;

    // newest producer wins, r0 never bypassed
    function automatic logic [1:0] pickSource(regAddrT src, exMemT em, memWbT mw);
        logic [1:0] sel;
        sel = FwdReg;
        if (src != '0) begin
            if (em.valid && em.ctrl.regWrite && em.rd == src) begin
                sel = FwdMem;
            end else if (mw.valid && mw.ctrl.regWrite && mw.rd == src) begin
                sel = FwdWb;
            end
        end
        return sel;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

endmodule

`default_nettype wire

// File: src/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  procPkg::regAddrT  decRs,
    input  procPkg::regAddrT  decRt,
    input  procPkg::idExT     idEx,
    input  logic              branchTaken,
    output logic              stall,
    output logic              flush
);
    // LD or POP in execute, data only exists after memory
    logic loadInEx;
    logic srcMatch;

    assign loadInEx = idEx.valid && idEx.ctrl.memRead && idEx.rd != '0;
    assign srcMatch = (idEx.rd == decRs) || (idEx.rd == decRt);

    // taken branch kills both younger slots
    assign flush = branchTaken;

    // fetch and decode test flush first, so flush wins there
    assign stall = loadInEx && srcMatch;

    // a load in execute is never a branch so both never rise together
    always_comb begin
        assert final (!(stall && flush))
            else $error("stall raised during flush");
    end

endmodule

`default_nettype wire

// File: src/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
    parameter int DmemDepth  = 256,
    parameter int StackDepth = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::exMemT  exMem,
    output procPkg::memWbT  memWb,
    output procPkg::dataT   memFwdData,
    output logic            stackOverflow
);
    import procPkg::*;

    localparam int             Daw   = $clog2(DmemDepth);
    localparam logic [Daw-1:0] SpTop = Daw'(DmemDepth - 1);

    // one array for data and stack, stack grows down from the top
    dataT           dmem [DmemDepth];
    dataT           rdData;
    logic [Daw-1:0] sp;
    logic [Daw-1:0] spUp;
    logic [Daw-1:0] addr;
    logic           live;
    logic           stackEmpty;
    logic           stackFull;
    logic           pushEn;
    logic           popEn;
    logic           pushOverflow;

    // nothing commits once the stack has overflowed
    assign live = exMem.valid && !stackOverflow;

    assign stackEmpty   = (sp == SpTop);
    assign stackFull    = ((SpTop - sp) == Daw'(StackDepth));
    assign pushEn       = live && exMem.ctrl.isPush && !stackFull;
    assign pushOverflow = live && exMem.ctrl.isPush && stackFull;
    assign popEn        = live && exMem.ctrl.isPop && !stackEmpty;
    assign spUp         = sp + 1'b1;

    // push at sp, pop from sp+1, else the computed address
    always_comb begin
        if (exMem.ctrl.isPush) begin
            addr = sp;
        end else if (exMem.ctrl.isPop) begin
            addr = spUp;
        end else begin
            addr = exMem.result[Daw-1:0];
        end
    end

    assign rdData = dmem[addr];

    always_ff @(posedge clk) begin
        if (pushEn || (live && exMem.ctrl.memWrite)) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    // loaded value already visible to the bypass
    assign memFwdData = exMem.ctrl.memToReg ? rdData : exMem.result;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sp            <= SpTop;
            stackOverflow <= 1'b0;
            memWb         <= '0;
        end else begin
            if (pushEn) begin
                sp <= sp - 1'b1;
            end else if (popEn) begin
                sp <= spUp;
            end
            // sticky until reset
            if (pushOverflow) begin
                stackOverflow <= 1'b1;
            end
            memWb.pc      <= exMem.pc;
            memWb.ctrl    <= exMem.ctrl;
            memWb.result  <= exMem.result;
            memWb.memData <= rdData;
            memWb.rd      <= exMem.rd;
            memWb.valid   <= live && !pushOverflow;
        end
    end

    // empty pop is flagged, sp stays parked at the top
    assert property (@(posedge clk) disable iff (!rstN)
        !(live && exMem.ctrl.isPop && stackEmpty))
        else $warning("POP from empty stack");

    // sp stays inside the stack window, no wrap past the top
    assert property (@(posedge clk) disable iff (!rstN)
        (SpTop - sp) <= Daw'(StackDepth))
        else $error("stack pointer moved past the top");

endmodule

`default_nettype wire

// File: src/procPkg.sv
`default_nettype none

package procPkg;

    typedef logic [15:0] dataT;
    typedef logic [2:0]  regAddrT;

    // major opcode, always bits 15:12
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ALU  = 4'h1,  // rd = rs func rt
        ADDI = 4'h2,  // rd = rs + imm
        LD   = 4'h3,  // rd = mem[rs + imm]
        ST   = 4'h4,  // mem[rs + imm] = rd
        PUSH = 4'h5,  // mem[sp] = rs, then sp--
        POP  = 4'h6,  // sp++, then rd = mem[sp]
        IN   = 4'h7,  // rd = inPort
        OUT  = 4'h8,  // outPort = rs
        JZ   = 4'h9,  // pc = rs if zero flag
        JMP  = 4'hA,  // pc = rs
        HALT = 4'hB
    } opcodeT;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SHL = 3'd5,
        SHR = 3'd6,
        NOT = 3'd7
    } aluFuncT;

    // register form, func in the low bits
    typedef struct packed {
        opcodeT  opcode;
        regAddrT rd;
        regAddrT rs;
        regAddrT rt;
        aluFuncT func;
    } regFormT;

    // immediate form, rt and func give way to a signed constant
    typedef struct packed {
        opcodeT             opcode;
        regAddrT            rd;
        regAddrT            rs;
        logic signed [5:0]  imm;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWordT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    useImm;
        logic    isPush;
        logic    isPop;
        logic    isIn;
        logic    isOut;
        logic    isJz;
        logic    isJmp;
        logic    isHalt;
        aluFuncT aluFunc;
    } ctrlT;

    typedef struct packed {
        dataT      pc;
        instrWordT instr;
        logic      valid;
    } ifIdT;

    typedef struct packed {
        dataT    pc;
        ctrlT    ctrl;
        dataT    opA;
        dataT    opB;
        dataT    imm;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        logic    valid;
    } idExT;

    typedef struct packed {
        dataT    pc;
        ctrlT    ctrl;
        dataT    result;
        dataT    storeData;
        regAddrT rd;
        logic    valid;
    } exMemT;

    typedef struct packed {
        dataT    pc;
        ctrlT    ctrl;
        dataT    result;
        dataT    memData;
        regAddrT rd;
        logic    valid;
    } memWbT;

    // operand bypass selects
    localparam logic [1:0] FwdReg = 2'd0;
    localparam logic [1:0] FwdMem = 2'd1;
    localparam logic [1:0] FwdWb  = 2'd2;

endpackage

`default_nettype wire

// File: src/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor #(
    parameter int ImemDepth  = 256,
    parameter int DmemDepth  = 256,
    parameter int StackDepth = 16
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           progWe,
    input  procPkg::dataT  progAddr,
    input  procPkg::dataT  progData,
    input  procPkg::dataT  inPort,
    output procPkg::dataT  outPort,
    output logic           outValid,
    output logic           halted,
    output logic           stackOverflow
);
    import procPkg::*;

    // pipeline registers
    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;

    // hazard and bypass
    regAddrT    decRs;
    regAddrT    decRt;
    logic       stall;
    logic       flush;
    logic       branchTaken;
    dataT       branchTarget;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    dataT       memFwdData;

    // writeback port into the register file
    logic    wbEn;
    regAddrT wbAddr;
    dataT    wbData;

    // fetch goes quiet after HALT retires or the stack overflows
    logic stop;
    assign stop = halted || stackOverflow;

    fetchStage #(
        .ImemDepth(ImemDepth)
    ) uFetch (
        .clk(clk),
        .rstN(rstN),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .stall(stall),
        .flush(flush),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .stop(stop),
        .ifId(ifId)
    );

    decodeStage uDecode (
        .clk(clk),
        .rstN(rstN),
        .ifId(ifId),
        .stall(stall),
        .flush(flush),
        .wbEn(wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .inPort(inPort),
        .idEx(idEx),
        .decRs(decRs),
        .decRt(decRt)
    );

    hazardUnit uHazard (
        .decRs(decRs),
        .decRt(decRt),
        .idEx(idEx),
        .branchTaken(branchTaken),
        .stall(stall),
        .flush(flush)
    );

    forwardUnit uForward (
        .idEx(idEx),
        .exMem(exMem),
        .memWb(memWb),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    executeStage uExecute (
        .clk(clk),
        .rstN(rstN),
        .idEx(idEx),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .exFwdData(memFwdData),
        .wbFwdData(wbData),
        .exMem(exMem),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    memoryStage #(
        .DmemDepth(DmemDepth),
        .StackDepth(StackDepth)
    ) uMemory (
        .clk(clk),
        .rstN(rstN),
        .exMem(exMem),
        .memWb(memWb),
        .memFwdData(memFwdData),
        .stackOverflow(stackOverflow)
    );

    // writeback select, loads and pops take the memory word
    assign wbEn   = memWb.valid && memWb.ctrl.regWrite;
    assign wbAddr = memWb.rd;
    assign wbData = memWb.ctrl.memToReg ? memWb.memData : memWb.result;

    // output register and halt latch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outPort  <= '0;
            outValid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            outValid <= memWb.valid && memWb.ctrl.isOut;
            if (memWb.valid && memWb.ctrl.isOut) begin
                outPort <= memWb.result;
            end
            if (memWb.valid && memWb.ctrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
